// ==== logic/motor_defs.svh ====
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// SPI frame layout
`define FRAME_BITS      40
`define OP_BITS         8
`define DATA_BITS       32
`define BITCNT_BITS     6   // Saturating bit counter

`define POS_BITS        32  // Encoder count

// Motion configuration
`define STEP_CNT_BITS   16  // Period and step count fields
`define CURRENT_BITS    8
`define MICRO_BITS      3
`define MICRO_MAX       6
`define PERIOD_DEFAULT  1000
`define PERIOD_MIN      2

// One electrical cycle is 256 angle counts
`define ANGLE_BITS      8
`define PWM_BITS        8
`define SINE_ENTRIES    64

`endif

// ==== logic/motor_pkg.sv ====
`include "motor_defs.svh"

package motor_pkg;

  // Command opcodes in the first byte of a frame
  typedef enum logic [`OP_BITS-1:0] {
    OP_NOP            = 8'd0,
    OP_ENABLE         = 8'd1,
    OP_SET_CURRENT    = 8'd2,
    OP_SET_MICROSTEPS = 8'd3,
    OP_SET_PERIOD     = 8'd4,
    OP_MOVE           = 8'd5,
    OP_STOP           = 8'd6
  } cmd_op_t;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_t;

  typedef enum logic [1:0] {
    MV_IDLE,
    MV_WAIT,
    MV_STEP
  } move_state_t;

endpackage

// ==== logic/spi_command_port.sv ====
`include "motor_defs.svh"

module spi_command_port import motor_pkg::*; (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    copi,
  output logic                    cipo,
  input  logic [`POS_BITS-1:0]    position,
  input  logic                    enc_fault,
  input  logic                    busy,
  input  logic [`MICRO_BITS-1:0]  microsteps,
  output logic                    cmd_valid,
  output cmd_op_t                 cmd_op,
  output logic [`DATA_BITS-1:0]   cmd_data
);

  logic [2:0]                sck_q;   // Two sync stages plus edge history
  logic [2:0]                cs_q;
  logic [1:0]                copi_q;
  logic                      sck_rise;
  logic                      sck_fall;
  logic                      cs_fall;
  logic                      cs_rise;
  spi_state_t                state;
  logic [`BITCNT_BITS-1:0]   bit_cnt;
  logic [`FRAME_BITS-1:0]    rx_shift;
  logic [`FRAME_BITS-1:0]    tx_shift;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= 3'b000;
      cs_q   <= 3'b111;   // Deselected
      copi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      copi_q <= {copi_q[0], copi};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];

  // Frame FSM
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state   <= SPI_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        SPI_IDLE: begin
          if (cs_fall) begin
            state   <= SPI_SHIFT;
            bit_cnt <= '0;
          end
        end
        SPI_SHIFT: begin
          if (cs_rise) begin
            state <= SPI_DONE;
          end else if (sck_rise && bit_cnt != '1) begin
            bit_cnt <= bit_cnt + 1'b1;  // Stops at all ones so long frames never alias to 40
          end
        end
        default: state <= SPI_IDLE;  // Command strobe lasts one cycle
      endcase
    end
  end

  // Reply is captured once per frame so it cannot tear mid-shift
  always_ff @(posedge CLK) begin
    if (state == SPI_IDLE && cs_fall) begin
      tx_shift <= {busy, enc_fault, 3'b000, microsteps, position};
    end else if (state == SPI_SHIFT && sck_fall) begin
      tx_shift <= {tx_shift[`FRAME_BITS-2:0], 1'b0};
    end
    if (state == SPI_SHIFT && sck_rise) begin
      rx_shift <= {rx_shift[`FRAME_BITS-2:0], copi_q[1]};
    end
  end

  assign cipo = tx_shift[`FRAME_BITS-1];  // MSB first

  // Only a complete frame reaches the move controller
  assign cmd_valid = (state == SPI_DONE) && (bit_cnt == `BITCNT_BITS'(`FRAME_BITS));
  assign cmd_op    = cmd_op_t'(rx_shift[`FRAME_BITS-1 -: `OP_BITS]);
  assign cmd_data  = rx_shift[`DATA_BITS-1:0];

endmodule

// ==== logic/quad_decoder.sv ====
`include "motor_defs.svh"

module quad_decoder (
  input  logic                        CLK,
  input  logic                        resetn,
  input  logic                        enc_a,
  input  logic                        enc_b,
  output logic signed [`POS_BITS-1:0] position,
  output logic                        enc_fault
);

  logic [1:0] a_q;
  logic [1:0] b_q;
  logic [1:0] cur_ab;
  logic [1:0] prev_ab;

  // Free running synchronizers
  always_ff @(posedge CLK) begin
    a_q <= {a_q[0], enc_a};
    b_q <= {b_q[0], enc_b};
  end

  assign cur_ab = {a_q[1], b_q[1]};

  // Previous A/B state for edge detection
  always_ff @(posedge CLK) begin
    prev_ab <= cur_ab;
  end

  // Forward order of {a, b} is 00, 10, 11, 01 with A leading B
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      position  <= '0;
      enc_fault <= 1'b0;
    end else begin
      case ({prev_ab, cur_ab})
        4'b0010,
        4'b1011,
        4'b1101,
        4'b0100: position <= position + 1'b1;
        4'b0001,
        4'b0111,
        4'b1110,
        4'b1000: position <= position - 1'b1;
        // Both lines moved at once so the direction is lost
        4'b0011,
        4'b1100,
        4'b0110,
        4'b1001: enc_fault <= 1'b1;
        default: ;  // No change
      endcase
    end
  end

endmodule

// ==== logic/move_controller.sv ====
`include "motor_defs.svh"

module move_controller import motor_pkg::*; (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic                       cmd_valid,
  input  cmd_op_t                    cmd_op,
  input  logic [`DATA_BITS-1:0]      cmd_data,
  output logic                       step_pulse,
  output logic                       dir,
  output logic                       enable,
  output logic [`CURRENT_BITS-1:0]   coil_current,
  output logic [`MICRO_BITS-1:0]     microsteps,
  output logic                       busy,
  output logic                       move_done
);

  move_state_t                 state;
  logic [`STEP_CNT_BITS-1:0]   period;
  logic [`STEP_CNT_BITS-1:0]   eff_period;
  logic [`STEP_CNT_BITS-1:0]   wait_cnt;
  logic [`STEP_CNT_BITS-1:0]   steps_left;
  logic [`MICRO_BITS-1:0]      micro_req;
  logic                        start_move;

  assign eff_period = (period < `STEP_CNT_BITS'(`PERIOD_MIN)) ?
                      `STEP_CNT_BITS'(`PERIOD_MIN) : period;
  assign micro_req  = cmd_data[`MICRO_BITS-1:0];

  // Moves are accepted only when enabled, idle and nonzero
  assign start_move = cmd_valid && (cmd_op == OP_MOVE) && enable && !busy &&
                      (cmd_data[`STEP_CNT_BITS-1:0] != '0);

  assign busy       = (state != MV_IDLE);
  assign step_pulse = (state == MV_STEP);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state        <= MV_IDLE;
      enable       <= 1'b0;
      dir          <= 1'b0;
      coil_current <= '0;
      microsteps   <= '0;
      period       <= `STEP_CNT_BITS'(`PERIOD_DEFAULT);
      wait_cnt     <= '0;
      steps_left   <= '0;
      move_done    <= 1'b0;
    end else begin
      move_done <= 1'b0;

      // Step timing
      case (state)
        MV_WAIT: begin
          if (wait_cnt == '0) begin
            state <= MV_STEP;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        MV_STEP: begin
          steps_left <= steps_left - 1'b1;
          if (steps_left == `STEP_CNT_BITS'(1)) begin
            state     <= MV_IDLE;
            move_done <= 1'b1;
          end else begin
            state    <= MV_WAIT;
            wait_cnt <= eff_period - `STEP_CNT_BITS'(2);  // STEP cycle counts toward the period
          end
        end
        default: ;
      endcase

      // Commands take priority over the step timing
      if (cmd_valid) begin
        case (cmd_op)
          OP_ENABLE: begin
            enable <= cmd_data[0];
            if (!cmd_data[0]) begin
              state     <= MV_IDLE;   // Abort without move_done
              move_done <= 1'b0;
            end
          end
          OP_SET_CURRENT:    coil_current <= cmd_data[`CURRENT_BITS-1:0];
          OP_SET_MICROSTEPS: microsteps <= (micro_req > `MICRO_BITS'(`MICRO_MAX)) ?
                                           `MICRO_BITS'(`MICRO_MAX) : micro_req;
          OP_SET_PERIOD:     period <= cmd_data[`STEP_CNT_BITS-1:0];
          OP_MOVE: begin
            if (start_move) begin
              dir        <= cmd_data[`DATA_BITS-1];
              steps_left <= cmd_data[`STEP_CNT_BITS-1:0];
              wait_cnt   <= eff_period - 1'b1;
              state      <= MV_WAIT;
            end
          end
          OP_STOP: begin
            state     <= MV_IDLE;
            move_done <= 1'b0;
          end
          default: ;  // NOP and unknown codes
        endcase
      end
    end
  end

endmodule

// ==== logic/phase_sequencer.sv ====
`include "motor_defs.svh"

module phase_sequencer (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic                       step_pulse,
  input  logic                       dir,
  input  logic                       enable,
  input  logic [`CURRENT_BITS-1:0]   coil_current,
  input  logic [`MICRO_BITS-1:0]     microsteps,
  output logic                       phase_a1,
  output logic                       phase_a2,
  output logic                       phase_b1,
  output logic                       phase_b2
);

  localparam logic [`ANGLE_BITS-1:0] QUARTER = `ANGLE_BITS'(`SINE_ENTRIES);

  // round(255 * sin(i * pi / 128))
  localparam logic [`PWM_BITS-1:0] SINE_TABLE [0:`SINE_ENTRIES-1] = '{
      0,   6,  13,  19,  25,  31,  37,  44,  50,  56,  62,  68,  74,  80,  86,  92,
     98, 103, 109, 115, 120, 126, 131, 136, 142, 147, 152, 157, 162, 167, 171, 176,
    180, 185, 189, 193, 197, 201, 205, 208, 212, 215, 219, 222, 225, 228, 231, 233,
    236, 238, 240, 242, 244, 246, 247, 249, 250, 251, 252, 253, 254, 254, 255, 255
  };

  logic [`ANGLE_BITS-1:0]                angle;
  logic [`ANGLE_BITS-1:0]                angle_a;
  logic [`ANGLE_BITS-1:0]                delta;
  logic [`PWM_BITS:0]                    fold_a;  // {negative, magnitude}
  logic [`PWM_BITS:0]                    fold_b;
  logic [`PWM_BITS+`CURRENT_BITS-1:0]    prod_a;
  logic [`PWM_BITS+`CURRENT_BITS-1:0]    prod_b;
  logic [`PWM_BITS-1:0]                  pwm_cnt;
  logic [`PWM_BITS-1:0]                  duty_a;
  logic [`PWM_BITS-1:0]                  duty_b;
  logic                                  neg_a;
  logic                                  neg_b;

  // Sine of an angle built from the quarter-wave table
  function automatic logic [`PWM_BITS:0] fold(input logic [`ANGLE_BITS-1:0] ang);
    logic [`ANGLE_BITS-3:0] idx;
    logic [`ANGLE_BITS-2:0] k;
    logic [`PWM_BITS-1:0]   mag;
    idx = ang[`ANGLE_BITS-3:0];
    // Odd quadrants run the table backwards
    k   = ang[`ANGLE_BITS-2] ? (QUARTER[`ANGLE_BITS-2:0] - {1'b0, idx}) : {1'b0, idx};
    mag = (k == QUARTER[`ANGLE_BITS-2:0]) ? '1 : SINE_TABLE[k[`ANGLE_BITS-3:0]];
    return {ang[`ANGLE_BITS-1], mag};
  endfunction

  assign delta = QUARTER >> microsteps;  // Full step is a quarter cycle

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      angle <= '0;
    end else if (step_pulse) begin
      angle <= dir ? angle + delta : angle - delta;
    end
  end

  assign angle_a = angle + QUARTER;  // Coil A takes the cosine
  assign fold_a  = fold(angle_a);
  assign fold_b  = fold(angle);
  assign prod_a  = fold_a[`PWM_BITS-1:0] * coil_current;
  assign prod_b  = fold_b[`PWM_BITS-1:0] * coil_current;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pwm_cnt  <= '0;
      duty_a   <= '0;
      duty_b   <= '0;
      neg_a    <= 1'b0;
      neg_b    <= 1'b0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      // New duty only at the wrap so a period is never split
      if (pwm_cnt == '1) begin
        duty_a <= prod_a[`PWM_BITS+`CURRENT_BITS-1 -: `PWM_BITS];
        duty_b <= prod_b[`PWM_BITS+`CURRENT_BITS-1 -: `PWM_BITS];
        neg_a  <= fold_a[`PWM_BITS];
        neg_b  <= fold_b[`PWM_BITS];
      end
      phase_a1 <= enable && !neg_a && (pwm_cnt < duty_a);
      phase_a2 <= enable &&  neg_a && (pwm_cnt < duty_a);
      phase_b1 <= enable && !neg_b && (pwm_cnt < duty_b);
      phase_b2 <= enable &&  neg_b && (pwm_cnt < duty_b);
    end
  end

endmodule

// ==== logic/motor_top.sv ====
`include "motor_defs.svh"

module motor_top import motor_pkg::*; (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic move_done,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  // Command strobe
  logic                      cmd_valid;
  cmd_op_t                   cmd_op;
  logic [`DATA_BITS-1:0]     cmd_data;

  // Encoder status
  logic [`POS_BITS-1:0]      position;
  logic                      enc_fault;

  // Stepper control lines
  logic                      step_pulse;
  logic                      dir;
  logic                      enable;
  logic [`CURRENT_BITS-1:0]  coil_current;
  logic [`MICRO_BITS-1:0]    microsteps;
  logic                      busy;

  spi_command_port spi0 (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .cipo       (cipo),
    .position   (position),
    .enc_fault  (enc_fault),
    .busy       (busy),
    .microsteps (microsteps),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_data   (cmd_data)
  );

  quad_decoder encoder0 (
    .CLK       (CLK),
    .resetn    (resetn),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .position  (position),
    .enc_fault (enc_fault)
  );

  move_controller mover0 (
    .CLK          (CLK),
    .resetn       (resetn),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_data     (cmd_data),
    .step_pulse   (step_pulse),
    .dir          (dir),
    .enable       (enable),
    .coil_current (coil_current),
    .microsteps   (microsteps),
    .busy         (busy),
    .move_done    (move_done)
  );

  phase_sequencer phases0 (
    .CLK          (CLK),
    .resetn       (resetn),
    .step_pulse   (step_pulse),
    .dir          (dir),
    .enable       (enable),
    .coil_current (coil_current),
    .microsteps   (microsteps),
    .phase_a1     (phase_a1),
    .phase_a2     (phase_a2),
    .phase_b1     (phase_b1),
    .phase_b2     (phase_b2)
  );

endmodule

// ==== testbench/tb_motor_top.sv ====
`include "motor_defs.svh"

module tb_motor_top import motor_pkg::*; ();

  localparam int HALF = 10;  // SCK half period in CLK cycles
  localparam int FRAME_CYCLES = (2 * `FRAME_BITS + 2) * HALF;
  localparam int CHK_STATUS = 0;
  localparam int CHK_FAULT = 1;
  localparam int CHK_MOVE = 2;
  localparam int CHK_IGNORED = 3;
  localparam int CHK_SHORT = 4;
  localparam int CHK_STOP = 5;

  typedef struct {
    cmd_op_t     op;
    logic [31:0] data;
    int          enc;  // Encoder steps before the frame, sign is direction
    int          chk;
  } entry_t;

  logic CLK, resetn, sck, cs_n, copi, enc_a, enc_b;
  logic cipo, move_done, phase_a1, phase_a2, phase_b1, phase_b2;

  entry_t      tests[$];
  int          sine_ref [0:`SINE_ENTRIES];
  logic [31:0] lfsr = 32'h180c;
  int          cycles = 0;
  int          limit = 32'h7fffffff;
  int          done_count = 0;
  int          done_cycle = 0;
  int          frame_end = 0;
  int          errors = 0;
  logic [7:0]  tb_pwm;
  logic [1:0]  enc_idx = 2'd0;

  // Reference model state
  logic        m_enable = 1'b0;
  logic [7:0]  m_current = 8'd0;
  logic [2:0]  m_micro = 3'd0;
  int          m_period = `PERIOD_DEFAULT;
  logic [7:0]  m_angle = 8'd0;
  logic [31:0] m_pos = 32'd0;
  logic        m_fault = 1'b0;

  motor_top dut (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs_n(cs_n), .copi(copi),
    .enc_a(enc_a), .enc_b(enc_b), .cipo(cipo), .move_done(move_done),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Cycle count, move_done log, PWM position and the run limit
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    tb_pwm <= resetn ? tb_pwm + 8'd1 : 8'd0;
    if (move_done) begin
      done_count <= done_count + 1;
      done_cycle <= cycles;
    end
    if (cycles >= limit) begin
      $display("Timeout: run exceeded %0d cycles", limit);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // Galois step
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [1:0] gray_code(input logic [1:0] idx);
    case (idx)
      2'd0: return 2'b00;
      2'd1: return 2'b10;
      2'd2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  // {negative, duty} for a coil at the given electrical angle
  function automatic logic [8:0] coil_duty(input logic [7:0] ang);
    int k;
    k = ang[6] ? (64 - ang[5:0]) : ang[5:0];
    return {ang[7], 8'((sine_ref[k] * m_current) >> 8)};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic add_entry(input cmd_op_t op, input logic [31:0] data, input int enc,
                           input int chk);
    entry_t e;
    e.op = op;
    e.data = data;
    e.enc = enc;
    e.chk = chk;
    tests.push_back(e);
  endtask

  task automatic build_table();
    int period;
    add_entry(OP_NOP, 32'd0, 1 + rand_bits(4), CHK_STATUS);
    add_entry(OP_NOP, 32'd0, -(1 + rand_bits(5)), CHK_STATUS);
    add_entry(OP_NOP, 32'd0, rand_bits(1) ? 20 : -20, CHK_STATUS);
    add_entry(OP_NOP, 32'd0, 0, CHK_FAULT);
    add_entry(OP_NOP, 32'd0, 3, CHK_STATUS);  // Counting goes on after a fault
    add_entry(OP_SET_PERIOD, 32'd40, 0, CHK_STATUS);
    add_entry(OP_SET_CURRENT, {25'd0, 1'b1, rand_bits(7)}, 0, CHK_STATUS);
    add_entry(OP_MOVE, {16'h8000, 16'(32 + rand_bits(5))}, 0, CHK_IGNORED);
    add_entry(OP_ENABLE, 32'd1, 0, CHK_STATUS);
    add_entry(OP_SET_MICROSTEPS, 32'd2, 0, CHK_STATUS);
    add_entry(OP_MOVE, {16'h8000, 16'(32 + rand_bits(5))}, 0, CHK_MOVE);
    add_entry(OP_MOVE, {16'h0000, 16'(32 + rand_bits(5))}, 0, CHK_MOVE);
    add_entry(OP_SET_MICROSTEPS, 32'd5, 0, CHK_STATUS);
    add_entry(OP_SET_CURRENT, {25'd0, 1'b1, rand_bits(7)}, 0, CHK_STATUS);
    add_entry(OP_MOVE, {16'h8000, 16'(32 + rand_bits(5))}, 0, CHK_MOVE);
    add_entry(OP_MOVE, {16'h0000, 16'(32 + rand_bits(5))}, 0, CHK_MOVE);
    add_entry(OP_MOVE, {16'h8000, 16'd40}, 0, CHK_SHORT);
    add_entry(OP_MOVE, {16'h8000, 16'd1000}, 0, CHK_STOP);  // Angle unknown after this
    period = `PERIOD_DEFAULT;
    limit = 5000;
    foreach (tests[i]) begin
      if (tests[i].op == OP_SET_PERIOD) period = tests[i].data[15:0];
      limit += 4 * FRAME_CYCLES + 8 * ((tests[i].enc < 0) ? -tests[i].enc : tests[i].enc);
      limit += 1024;  // Duty measurement
      if (tests[i].op == OP_MOVE) limit += tests[i].data[15:0] * period;
    end
  endtask

  // Sends the low nbits of tx, MSB first
  task automatic spi_frame(input logic [39:0] tx, input int nbits, output logic [39:0] rx);
    rx = '0;
    cs_n = 1'b0;
    repeat (HALF) @(negedge CLK);
    for (int i = 0; i < nbits; i++) begin
      copi = tx[nbits - 1 - i];
      repeat (HALF) @(negedge CLK);
      sck = 1'b1;
      rx = {rx[38:0], cipo};  // Host samples on the rising edge
      repeat (HALF) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (HALF) @(negedge CLK);
    cs_n = 1'b1;
    frame_end = cycles;
    repeat (HALF) @(negedge CLK);
  endtask

  task automatic step_encoder(input int n);
    int count;
    count = (n < 0) ? -n : n;
    for (int i = 0; i < count; i++) begin
      enc_idx = (n > 0) ? enc_idx + 2'd1 : enc_idx - 2'd1;
      {enc_a, enc_b} = gray_code(enc_idx);
      m_pos += (n > 0) ? 32'd1 : -32'd1;
      repeat (4) @(negedge CLK);
    end
  endtask

  task automatic check_status(input logic exp_busy);
    logic [39:0] reply;
    logic [7:0]  exp_st;
    exp_st = {exp_busy, m_fault, 3'b000, m_micro};
    spi_frame({OP_NOP, 32'd0}, 40, reply);
    if (reply[39:32] !== exp_st) report_mismatch("status", reply[39:32], exp_st);
    if (reply[31:0] !== m_pos) report_mismatch("position", reply[31:0], m_pos);
  endtask

  task automatic wait_pwm(input logic [7:0] value);
    do @(negedge CLK); while (tb_pwm != value);
  endtask

  // High cycles of each output over one whole PWM period
  task automatic check_duties();
    int cnt [4];
    int exp_cnt [4];
    logic [8:0] da;
    logic [8:0] db;
    da = coil_duty(m_angle + 8'd64);  // Coil A is the cosine
    db = coil_duty(m_angle);
    exp_cnt[0] = (m_enable && !da[8]) ? da[7:0] : 0;
    exp_cnt[1] = (m_enable && da[8]) ? da[7:0] : 0;
    exp_cnt[2] = (m_enable && !db[8]) ? db[7:0] : 0;
    exp_cnt[3] = (m_enable && db[8]) ? db[7:0] : 0;
    cnt = '{0, 0, 0, 0};
    wait_pwm(8'd0);  // Duty for the current angle loads at this wrap
    wait_pwm(8'd1);
    for (int i = 0; i < 256; i++) begin
      cnt[0] += phase_a1;
      cnt[1] += phase_a2;
      cnt[2] += phase_b1;
      cnt[3] += phase_b2;
      @(negedge CLK);
    end
    if (cnt[0] != exp_cnt[0]) report_mismatch("phase_a1", cnt[0], exp_cnt[0]);
    if (cnt[1] != exp_cnt[1]) report_mismatch("phase_a2", cnt[1], exp_cnt[1]);
    if (cnt[2] != exp_cnt[2]) report_mismatch("phase_b1", cnt[2], exp_cnt[2]);
    if (cnt[3] != exp_cnt[3]) report_mismatch("phase_b2", cnt[3], exp_cnt[3]);
  endtask

  initial begin
    entry_t      e;
    logic [39:0] reply;
    int          done_before;
    int          err_before;
    int          move_end;
    int          steps;
    int          waited;
    int          failed = 0;
    resetn = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    for (int k = 0; k <= `SINE_ENTRIES; k++) begin
      sine_ref[k] = $rtoi(255.0 * $sin(k * 3.14159265358979 / 128.0) + 0.5);
    end
    build_table();
    repeat (10) @(negedge CLK);
    resetn = 1'b1;
    repeat (5) @(negedge CLK);

    for (int t = 0; t < tests.size(); t++) begin
      e = tests[t];
      err_before = errors;
      step_encoder(e.enc);
      if (e.chk == CHK_FAULT) begin
        {enc_a, enc_b} = ~{enc_a, enc_b};  // Both lines at once
        enc_idx = enc_idx + 2'd2;
        m_fault = 1'b1;
        repeat (4) @(negedge CLK);
      end
      done_before = done_count;
      steps = e.data[15:0];
      spi_frame({e.op, e.data}, (e.chk == CHK_SHORT) ? 39 : 40, reply);
      move_end = frame_end;
      if (e.chk != CHK_SHORT) apply_model(e.op, e.data);
      check_status(e.chk == CHK_MOVE || e.chk == CHK_STOP);
      if (e.chk == CHK_MOVE) begin
        waited = 0;
        while (done_count == done_before && waited < steps * m_period + 200) begin
          @(negedge CLK);
          waited++;
        end
        if (done_count == done_before) begin
          $display("Move of %0d steps never signalled move_done", steps);
          errors++;
        end else if (done_cycle - move_end < steps * m_period ||
                     done_cycle - move_end > steps * m_period + 10) begin
          report_mismatch("move_done delay", done_cycle - move_end, steps * m_period);
        end
        if (e.data[31]) m_angle += 8'(steps * (64 >> m_micro));
        else m_angle -= 8'(steps * (64 >> m_micro));
        check_duties();
        check_status(1'b0);
      end else if (e.chk == CHK_STOP) begin
        spi_frame({OP_STOP, 32'd0}, 40, reply);
        check_status(1'b0);
        repeat (3 * m_period) @(negedge CLK);
      end else if (e.chk == CHK_IGNORED) begin
        repeat (steps * m_period + 100) @(negedge CLK);
        check_duties();
      end
      if (done_count != done_before + ((e.chk == CHK_MOVE) ? 1 : 0)) begin
        $display("Saw %0d move_done pulses during test %0d", done_count - done_before, t);
        errors++;
      end
      if (errors != err_before) failed++;
      $display("Test %0d %s check %0d: %s", t, e.op.name(), e.chk,
               (errors == err_before) ? "PASS" : "FAIL");
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests.size(),
             tests.size() - failed, failed, errors);
    if (failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  task automatic apply_model(input cmd_op_t op, input logic [31:0] data);
    case (op)
      OP_ENABLE:         m_enable = data[0];
      OP_SET_CURRENT:    m_current = data[7:0];
      OP_SET_MICROSTEPS: m_micro = data[2:0];
      OP_SET_PERIOD:     m_period = data[15:0];
      default: ;
    endcase
  endtask

endmodule

// ==== all.f ====
+incdir+logic
logic/motor_pkg.sv
logic/spi_command_port.sv
logic/quad_decoder.sv
logic/move_controller.sv
logic/phase_sequencer.sv
logic/motor_top.sv
testbench/tb_motor_top.sv
